/* src/dac_ctrl_defines.svh */
`ifndef DAC_CTRL_DEFINES_SVH
`define DAC_CTRL_DEFINES_SVH

//////////////////////////////////////////////////
// Command word layout
//////////////////////////////////////////////////

// Opcode in the top three bits
`define CMD_OP_MSB    31
`define CMD_OP_LSB    29
`define CMD_CONT_BIT  27  // Another command must follow
`define CMD_LDAC_BIT  26  // Pulse ldac when the command ends
`define CMD_DELAY_W   25  // Delay count in bits 24..0
`define CMD_CH_LSB    16  // Channel for SET_CAL and DAC_WR_CH

//////////////////////////////////////////////////
// DAC limits
//////////////////////////////////////////////////

`define DAC_VAL_W     16
`define DAC_CH_W      3
`define DAC_NUM_CH    8
// Offset binary midscale
`define DAC_MID       32767
`define DAC_CODE_BAD  65535  // Never sent to the DAC
`define ABS_CAL_MAX   4096   // Calibration magnitude limit

//////////////////////////////////////////////////
// SPI framing
//////////////////////////////////////////////////

`define SPI_FRAME_W   24
`define CS_GAP_W      5   // Chip select high time, up to 31 cycles

`endif

/* src/dac_cmd_pkg.sv */
`include "dac_ctrl_defines.svh"

package dac_cmd_pkg;

  // Command opcodes
  // Any other code is a bad command
  typedef enum logic [2:0] {
    NO_OP     = 3'd0,  // Timed delay
    SET_CAL   = 3'd1,  // Load one calibration value
    DAC_WR    = 3'd2,  // Update all eight channels
    DAC_WR_CH = 3'd3,  // Update one channel
    CANCEL    = 3'd7   // End a running delay early
  } dac_op_e;

  // Parser FSM
  typedef enum logic [2:0] {
    S_IDLE,
    S_DELAY,
    S_DAC_WR_DATA,  // Unpacking data words into samples
    S_DAC_WR_WAIT,  // Frames in flight or delay still running
    S_DAC_WR_CH,
    S_HALT          // Left only through reset
  } parser_state_e;

  // One item for the calibration stage
  typedef struct packed {
    logic                  is_cal;   // Table write rather than a sample
    logic [`DAC_CH_W-1:0]  channel;
    logic [`DAC_VAL_W-1:0] value;    // Raw code or signed calibration
    logic                  last;     // Final sample of the command
  } dac_sample_t;

  // Sticky error flags
  typedef struct packed {
    logic bad_cmd;
    logic cmd_buf_underflow;
    logic cal_oob;
    logic dac_val_oob;
    logic delay_too_short;
  } dac_status_t;

endpackage

/* src/dac_spi_pkg.sv */
`include "dac_ctrl_defines.svh"

package dac_spi_pkg;

  //////////////////////////////////////////////////
  // DAC serial register interface
  //////////////////////////////////////////////////

  // Command nibble at the head of every frame
  typedef enum logic [3:0] {
    REG_WRITE = 4'b0001  // Write input register, update on ldac
  } spi_op_e;

  // Sent MSB first
  // op(4) rsvd(1) channel(3) code(16)
  typedef struct packed {
    spi_op_e               op;
    logic                  rsvd;     // Always zero
    logic [`DAC_CH_W-1:0]  channel;
    logic [`DAC_VAL_W-1:0] code;     // Offset binary
  } spi_frame_t;

endpackage

/* src/dac_cmd_parser.sv */
`timescale 1ns/1ps
`include "dac_ctrl_defines.svh"

module dac_cmd_parser (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic [31:0]              cmd_buf_word,
  input  logic                     cmd_buf_empty,
  output logic                     cmd_buf_rd_en,
  output dac_cmd_pkg::dac_sample_t samp,
  output logic                     samp_valid,
  input  logic                     samp_ready,
  input  logic                     tx_done_last,
  input  logic                     cal_oob_err,
  input  logic                     val_oob_err,
  output logic                     ldac,
  output logic                     busy,
  output dac_cmd_pkg::dac_status_t status
);

  dac_cmd_pkg::parser_state_e state, state_nxt;
  dac_cmd_pkg::dac_op_e       op;
  dac_cmd_pkg::dac_sample_t   samp_nxt;
  dac_cmd_pkg::dac_status_t   err;          // Error events this cycle
  logic [`CMD_DELAY_W-1:0]    delay_timer;
  logic [`DAC_CH_W-1:0]       ch_cnt;       // Next channel of a DAC_WR
  logic delay_zero, slot_free, writes_done;
  logic do_ldac, expect_next, wr_done;
  logic cmd_done, cancel, take_cmd, pop_data, load_samp, load_delay;

  assign op          = dac_cmd_pkg::dac_op_e'(cmd_buf_word[`CMD_OP_MSB:`CMD_OP_LSB]);
  assign delay_zero  = (delay_timer == '0);
  assign slot_free   = !samp_valid || samp_ready;  // Output register free next cycle
  assign writes_done = wr_done || tx_done_last;
  assign busy        = (state != dac_cmd_pkg::S_IDLE);
  assign cmd_buf_rd_en = take_cmd || pop_data || cancel;

  //////////////////////////////////////////////////
  // Command decode
  //////////////////////////////////////////////////

  always_comb begin
    state_nxt  = state;
    samp_nxt   = samp;
    err        = '0;
    cmd_done   = 1'b0;
    cancel     = 1'b0;
    take_cmd   = 1'b0;
    pop_data   = 1'b0;
    load_samp  = 1'b0;
    load_delay = 1'b0;
    case (state)
      dac_cmd_pkg::S_DELAY: begin
        if (!cmd_buf_empty && op == dac_cmd_pkg::CANCEL) cancel = 1'b1;  // Ends without ldac
        else cmd_done = delay_zero;
      end
      dac_cmd_pkg::S_DAC_WR_DATA: begin
        if (delay_zero) begin
          err.delay_too_short = 1'b1;
        end else if (slot_free) begin
          if (cmd_buf_empty) begin
            err.cmd_buf_underflow = 1'b1;  // Data word due but missing
          end else begin
            // Even channel from the low half, odd from the high half
            load_samp        = 1'b1;
            samp_nxt.is_cal  = 1'b0;
            samp_nxt.channel = ch_cnt;
            samp_nxt.value   = ch_cnt[0] ? cmd_buf_word[2*`DAC_VAL_W-1:`DAC_VAL_W]
                                         : cmd_buf_word[`DAC_VAL_W-1:0];
            samp_nxt.last    = (ch_cnt == `DAC_NUM_CH - 1);
            pop_data         = ch_cnt[0];  // Word used up after its high half
            if (ch_cnt == `DAC_NUM_CH - 1) state_nxt = dac_cmd_pkg::S_DAC_WR_WAIT;
          end
        end
      end
      dac_cmd_pkg::S_DAC_WR_WAIT: begin
        if (!writes_done && delay_zero) err.delay_too_short = 1'b1;
        else cmd_done = writes_done && delay_zero;
      end
      dac_cmd_pkg::S_DAC_WR_CH: cmd_done = tx_done_last;
      default: ;
    endcase

    // Chain straight into the next command
    if (cancel) begin
      state_nxt = dac_cmd_pkg::S_IDLE;
    end else if (state == dac_cmd_pkg::S_IDLE || cmd_done) begin
      state_nxt = dac_cmd_pkg::S_IDLE;
      if (cmd_buf_empty) begin
        if (cmd_done && expect_next) err.cmd_buf_underflow = 1'b1;
      end else begin
        case (op)
          dac_cmd_pkg::NO_OP, dac_cmd_pkg::DAC_WR: begin
            take_cmd   = 1'b1;
            load_delay = 1'b1;
            state_nxt  = (op == dac_cmd_pkg::NO_OP) ? dac_cmd_pkg::S_DELAY
                                                    : dac_cmd_pkg::S_DAC_WR_DATA;
          end
          dac_cmd_pkg::SET_CAL, dac_cmd_pkg::DAC_WR_CH: begin
            if (slot_free) begin  // Otherwise wait in IDLE
              take_cmd         = 1'b1;
              load_samp        = 1'b1;
              samp_nxt.is_cal  = (op == dac_cmd_pkg::SET_CAL);
              samp_nxt.channel = cmd_buf_word[`CMD_CH_LSB +: `DAC_CH_W];
              samp_nxt.value   = cmd_buf_word[`DAC_VAL_W-1:0];
              samp_nxt.last    = (op == dac_cmd_pkg::DAC_WR_CH);
              if (op == dac_cmd_pkg::DAC_WR_CH) state_nxt = dac_cmd_pkg::S_DAC_WR_CH;
            end
          end
          dac_cmd_pkg::CANCEL: take_cmd = 1'b1;  // Nothing to cancel
          default: err.bad_cmd = 1'b1;
        endcase
      end
    end

    err.cal_oob     = cal_oob_err;
    err.dac_val_oob = val_oob_err;
    if (err != '0) state_nxt = dac_cmd_pkg::S_HALT;
  end

  //////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state       <= dac_cmd_pkg::S_IDLE;
      status      <= '0;
      ldac        <= 1'b0;
      delay_timer <= '0;
      do_ldac     <= 1'b0;
      expect_next <= 1'b0;
      wr_done     <= 1'b0;
      ch_cnt      <= '0;
      samp_valid  <= 1'b0;
    end else begin
      state  <= state_nxt;
      status <= status | err;  // Sticky until reset
      ldac   <= cmd_done && do_ldac && (err == '0);

      // Delay runs regardless of back-pressure
      if (cancel || state == dac_cmd_pkg::S_HALT) delay_timer <= '0;
      else if (load_delay) delay_timer <= cmd_buf_word[`CMD_DELAY_W-1:0];
      else if (!delay_zero) delay_timer <= delay_timer - 1'b1;

      if (take_cmd) begin
        do_ldac     <= (op == dac_cmd_pkg::DAC_WR_CH) ||
                       (load_delay && cmd_buf_word[`CMD_LDAC_BIT]);
        expect_next <= load_delay && cmd_buf_word[`CMD_CONT_BIT];
      end

      if (take_cmd) wr_done <= 1'b0;
      else if (tx_done_last) wr_done <= 1'b1;

      if (take_cmd) ch_cnt <= '0;
      else if (load_samp) ch_cnt <= ch_cnt + 1'b1;

      // Output slot
      if (state == dac_cmd_pkg::S_HALT) samp_valid <= 1'b0;
      else if (load_samp) samp_valid <= 1'b1;
      else if (samp_ready) samp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_samp) samp <= samp_nxt;
  end

  // Buffer model only pops a present head
  assert property (@(posedge clk) disable iff (!resetn) cmd_buf_rd_en |-> !cmd_buf_empty)
    else $error("Command buffer read while empty");

endmodule

/* src/dac_cal_stage.sv */
`timescale 1ns/1ps
`include "dac_ctrl_defines.svh"

module dac_cal_stage (
  input  logic                     clk,
  input  logic                     resetn,
  input  dac_cmd_pkg::dac_sample_t samp,
  input  logic                     samp_valid,
  output logic                     samp_ready,
  output dac_spi_pkg::spi_frame_t  frame,
  output logic                     frame_valid,
  output logic                     frame_last,
  input  logic                     frame_ready,
  output logic                     cal_oob_err,
  output logic                     val_oob_err
);

  logic signed [`DAC_VAL_W-1:0] cal_tbl [`DAC_NUM_CH];  // Per-channel offsets
  logic signed [`DAC_VAL_W-1:0] cal_val;
  logic signed [`DAC_VAL_W+1:0] sum;                    // Code plus offset, two spare bits
  logic samp_fire, cal_ok, sum_ok, cal_wr, frame_ld;

  // Room when empty or when the held frame leaves this cycle
  assign samp_ready = !frame_valid || frame_ready;
  assign samp_fire  = samp_valid && samp_ready;

  //////////////////////////////////////////////////
  // Calibration and range check
  //////////////////////////////////////////////////

  assign cal_val = $signed(samp.value);
  assign cal_ok  = (cal_val <= `ABS_CAL_MAX) && (cal_val >= -`ABS_CAL_MAX);
  assign sum     = $signed({2'b00, samp.value}) + cal_tbl[samp.channel];  // Sign-extends cal
  // 65535 is rejected before calibration
  assign sum_ok  = (samp.value != `DAC_CODE_BAD) && (sum >= 0) && (sum <= 2 * `DAC_MID);

  assign cal_wr   = samp_fire && samp.is_cal && cal_ok;
  assign frame_ld = samp_fire && !samp.is_cal && sum_ok;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < `DAC_NUM_CH; i++) begin
        cal_tbl[i] <= '0;
      end
      frame_valid <= 1'b0;
      cal_oob_err <= 1'b0;
      val_oob_err <= 1'b0;
    end else begin
      cal_oob_err <= samp_fire && samp.is_cal && !cal_ok;   // Table left unchanged
      val_oob_err <= samp_fire && !samp.is_cal && !sum_ok;  // Sample dropped
      if (cal_wr) cal_tbl[samp.channel] <= cal_val;
      if (frame_ld) frame_valid <= 1'b1;
      else if (frame_ready) frame_valid <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Output frame
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (frame_ld) begin
      frame.op      <= dac_spi_pkg::REG_WRITE;
      frame.rsvd    <= 1'b0;
      frame.channel <= samp.channel;
      frame.code    <= sum[`DAC_VAL_W-1:0];  // Known in range here
      frame_last    <= samp.last;
    end
  end

  // Held frame may not change under back-pressure
  assert property (@(posedge clk) disable iff (!resetn)
                   frame_valid && !frame_ready |=> frame_valid && $stable(frame))
    else $error("Frame changed while stalled");

endmodule

/* src/dac_spi_tx.sv */
`timescale 1ns/1ps
`include "dac_ctrl_defines.svh"

module dac_spi_tx (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic [`CS_GAP_W-1:0]    n_cs_high_time,
  input  dac_spi_pkg::spi_frame_t frame,
  input  logic                    frame_valid,
  input  logic                    frame_last,
  output logic                    frame_ready,
  output logic                    tx_done_last,
  output logic                    n_cs,
  output logic                    mosi
);

  localparam int BIT_CNT_W = $clog2(`SPI_FRAME_W);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_GAP,    // n_cs high before the frame
    TX_SHIFT
  } tx_state_e;

  tx_state_e               state;
  logic [`CS_GAP_W-1:0]    gap_lat;   // Captured while in reset
  logic [`CS_GAP_W-1:0]    gap_cnt;
  logic [BIT_CNT_W-1:0]    bit_cnt;   // Bits left after the current one
  logic [`SPI_FRAME_W-1:0] shreg;
  logic                    last_lat;
  logic                    accept;

  assign frame_ready = (state == TX_IDLE);
  assign accept      = frame_valid && frame_ready;
  assign mosi        = !n_cs && shreg[`SPI_FRAME_W-1];  // Quiet low between frames

  //////////////////////////////////////////////////
  // Chip select and bit timing
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      gap_lat      <= n_cs_high_time;
      state        <= TX_IDLE;
      n_cs         <= 1'b1;
      tx_done_last <= 1'b0;
      gap_cnt      <= '0;
      bit_cnt      <= '0;
    end else begin
      tx_done_last <= 1'b0;
      case (state)
        TX_IDLE: begin
          if (accept && gap_lat == '0) begin  // No gap, start at once
            state   <= TX_SHIFT;
            n_cs    <= 1'b0;
            bit_cnt <= BIT_CNT_W'(`SPI_FRAME_W - 1);
          end else if (accept) begin
            state   <= TX_GAP;
            gap_cnt <= gap_lat - 1'b1;
          end
        end
        TX_GAP: begin
          if (gap_cnt == '0) begin
            state   <= TX_SHIFT;
            n_cs    <= 1'b0;
            bit_cnt <= BIT_CNT_W'(`SPI_FRAME_W - 1);
          end else begin
            gap_cnt <= gap_cnt - 1'b1;
          end
        end
        TX_SHIFT: begin
          if (bit_cnt == '0) begin
            state        <= TX_IDLE;
            n_cs         <= 1'b1;
            tx_done_last <= last_lat;  // Command's final frame is out
          end else begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // MSB first
  always_ff @(posedge clk) begin
    if (accept) begin
      shreg    <= frame;
      last_lat <= frame_last;
    end else if (state == TX_SHIFT) begin
      shreg <= {shreg[`SPI_FRAME_W-2:0], 1'b0};
    end
  end

  // Every select window is one full frame
  assert property (@(posedge clk) disable iff (!resetn) $fell(n_cs) |-> ##(`SPI_FRAME_W) n_cs)
    else $error("n_cs low window is not one frame long");

endmodule

/* src/dac_ctrl_top.sv */
`timescale 1ns/1ps
`include "dac_ctrl_defines.svh"

module dac_ctrl_top (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic [31:0]              cmd_buf_word,
  input  logic                     cmd_buf_empty,
  output logic                     cmd_buf_rd_en,
  input  logic [`CS_GAP_W-1:0]     n_cs_high_time,
  output logic                     n_cs,
  output logic                     mosi,
  output logic                     ldac,
  output logic                     busy,
  output dac_cmd_pkg::dac_status_t status
);

  //////////////////////////////////////////////////
  // Stage links
  //////////////////////////////////////////////////

  dac_cmd_pkg::dac_sample_t samp;
  logic                     samp_valid, samp_ready;
  dac_spi_pkg::spi_frame_t  frame;
  logic                     frame_valid, frame_last, frame_ready;
  logic                     tx_done_last;                // Ends DAC_WR and DAC_WR_CH
  logic                     cal_oob_err, val_oob_err;    // Error pulses to the parser

  // Command FSM, delay and ldac
  dac_cmd_parser u_parser (
    .clk           (clk),
    .resetn        (resetn),
    .cmd_buf_word  (cmd_buf_word),
    .cmd_buf_empty (cmd_buf_empty),
    .cmd_buf_rd_en (cmd_buf_rd_en),
    .samp          (samp),
    .samp_valid    (samp_valid),
    .samp_ready    (samp_ready),
    .tx_done_last  (tx_done_last),
    .cal_oob_err   (cal_oob_err),
    .val_oob_err   (val_oob_err),
    .ldac          (ldac),
    .busy          (busy),
    .status        (status)
  );

  // Offset table and frame build
  dac_cal_stage u_cal (
    .clk         (clk),
    .resetn      (resetn),
    .samp        (samp),
    .samp_valid  (samp_valid),
    .samp_ready  (samp_ready),
    .frame       (frame),
    .frame_valid (frame_valid),
    .frame_last  (frame_last),
    .frame_ready (frame_ready),
    .cal_oob_err (cal_oob_err),
    .val_oob_err (val_oob_err)
  );

  dac_spi_tx u_spi (
    .clk            (clk),
    .resetn         (resetn),
    .n_cs_high_time (n_cs_high_time),
    .frame          (frame),
    .frame_valid    (frame_valid),
    .frame_last     (frame_last),
    .frame_ready    (frame_ready),
    .tx_done_last   (tx_done_last),
    .n_cs           (n_cs),
    .mosi           (mosi)
  );

endmodule

/* verif/tb_dac_ctrl_tasks.svh */
`ifndef TB_DAC_CTRL_TASKS_SVH
`define TB_DAC_CTRL_TASKS_SVH

//////////////////////////////////////////////////
// Command words and sequencing
//////////////////////////////////////////////////

function automatic logic [31:0] delay_cmd(input logic [2:0] op, input logic ldac_en,
                                          input logic [`CMD_DELAY_W-1:0] delay);
  logic [31:0] w;
  w = '0;
  w[`CMD_OP_MSB:`CMD_OP_LSB] = op;
  w[`CMD_LDAC_BIT]           = ldac_en;
  w[`CMD_DELAY_W-1:0]        = delay;
  return w;
endfunction

// SET_CAL and DAC_WR_CH layout
function automatic logic [31:0] chan_cmd(input logic [2:0] op, input logic [`DAC_CH_W-1:0] ch,
                                         input logic [`DAC_VAL_W-1:0] value);
  logic [31:0] w;
  w = '0;
  w[`CMD_OP_MSB:`CMD_OP_LSB]    = op;
  w[`CMD_CH_LSB +: `DAC_CH_W]   = ch;
  w[`DAC_VAL_W-1:0]             = value;
  return w;
endfunction

// Commands are queued while reset is still low
task automatic begin_test(input string name);
  @(negedge clk);
  resetn = 1'b0;
  cmd_q.delete();
  obs_q.delete();
  @(negedge clk);
  $display("Running %s", name);
endtask

task automatic release_reset();
  repeat (4) @(negedge clk);
  resetn = 1'b1;
endtask

task automatic wait_for(input string what, input int limit);
  logic hit;
  int   n;
  hit = 1'b0;
  n   = 0;
  while (!hit) begin
    if (n == limit) begin
      report_failure({"Timed out waiting for ", what});
    end else begin
      @(negedge clk);
      n++;
      if (what == "ldac") hit = (ldac_cnt != 0);
      else if (what == "status") hit = (status != '0);
      else hit = !busy;  // Sequence finished
    end
  end
endtask

// Halted controller sends nothing
task automatic check_quiet(input int cycles);
  for (int i = 0; i < cycles; i++) begin
    @(negedge clk);
    if (!n_cs) report_failure("n_cs went low after the controller halted");
  end
  compare_count(obs_q.size(), 0, "frames after halt");
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic test_single_channel();
  logic [`DAC_VAL_W-1:0] code;
  begin_test("single channel write");
  code = `DAC_VAL_W'(take_bits(`DAC_VAL_W));
  if (code == `DAC_VAL_W'(`DAC_CODE_BAD)) code = `DAC_VAL_W'(`DAC_MID);
  cmd_q.push_back(chan_cmd(dac_cmd_pkg::DAC_WR_CH, 3'd5, code));
  release_reset();
  wait_for("ldac", 200);
  repeat (3) @(negedge clk);
  compare_count(obs_q.size(), 1, "frame count");
  compare_frame(obs_q[0], make_frame(3'd5, code), "channel 5");
  compare_count(ldac_cnt, 1, "ldac pulses");
  compare_status(status, '0, "single write");
endtask

task automatic test_full_update();
  logic [`DAC_VAL_W-1:0] cal  [`DAC_NUM_CH];
  logic [`DAC_VAL_W-1:0] code [`DAC_NUM_CH];
  int                    sum;
  begin_test("full update with calibration");
  for (int ch = 0; ch < `DAC_NUM_CH; ch++) begin
    cal[ch]  = `DAC_VAL_W'(int'(take_bits(13)) - `ABS_CAL_MAX);  // -4096 to 4095
    code[ch] = `DAC_VAL_W'(take_bits(`DAC_VAL_W));
    sum      = int'(code[ch]) + int'($signed(cal[ch]));
    // Forbidden code is rejected whatever the offset
    if (sum < 0 || sum > 2 * `DAC_MID || code[ch] == `DAC_VAL_W'(`DAC_CODE_BAD))
      code[ch] = `DAC_VAL_W'(`DAC_MID);
    cmd_q.push_back(chan_cmd(dac_cmd_pkg::SET_CAL, 3'(ch), cal[ch]));
  end
  cmd_q.push_back(delay_cmd(dac_cmd_pkg::DAC_WR, 1'b1, 25'd1000));  // Outlasts 8 frames
  for (int w = 0; w < `DAC_NUM_CH / 2; w++) begin
    cmd_q.push_back({code[2*w+1], code[2*w]});  // Odd channel in the high half
  end
  release_reset();
  wait_for("ldac", 1500);
  repeat (3) @(negedge clk);
  compare_count(obs_q.size(), `DAC_NUM_CH, "frame count");
  for (int ch = 0; ch < `DAC_NUM_CH; ch++) begin
    sum = int'(code[ch]) + int'($signed(cal[ch]));
    compare_frame(obs_q[ch], make_frame(3'(ch), `DAC_VAL_W'(sum)), "calibrated channel");
  end
  compare_count(ldac_cnt, 1, "ldac pulses");
  compare_count(int'(busy), 0, "busy");
  compare_status(status, '0, "full update");
endtask

task automatic test_cancel_delay();
  begin_test("cancel a delay");
  cmd_q.push_back(delay_cmd(dac_cmd_pkg::NO_OP, 1'b1, 25'd5000));
  cmd_q.push_back(delay_cmd(dac_cmd_pkg::CANCEL, 1'b0, '0));
  release_reset();
  @(negedge clk);
  compare_count(int'(busy), 1, "busy during delay");  // NO_OP taken
  wait_for("idle", 100);  // Far shorter than the delay
  repeat (20) @(negedge clk);
  compare_count(ldac_cnt, 0, "ldac pulses");
  compare_count(int'(busy), 0, "busy");
  compare_status(status, '0, "cancel");
endtask

task automatic test_cal_out_of_range();
  dac_cmd_pkg::dac_status_t exp;
  begin_test("calibration out of range");
  cmd_q.push_back(chan_cmd(dac_cmd_pkg::SET_CAL, 3'd2, 16'd5000));
  release_reset();
  wait_for("status", 100);
  check_quiet(60);
  exp         = '0;
  exp.cal_oob = 1'b1;
  compare_status(status, exp, "large calibration");
endtask

task automatic test_bad_cmd_short_delay();
  dac_cmd_pkg::dac_status_t exp;
  begin_test("unknown opcode");
  cmd_q.push_back(delay_cmd(3'd5, 1'b0, '0));
  release_reset();
  wait_for("status", 100);
  repeat (5) @(negedge clk);
  exp         = '0;
  exp.bad_cmd = 1'b1;
  compare_status(status, exp, "opcode 5");

  begin_test("delay too short");
  cmd_q.push_back(delay_cmd(dac_cmd_pkg::DAC_WR, 1'b1, 25'd10));
  repeat (`DAC_NUM_CH / 2) cmd_q.push_back({16'(`DAC_MID), 16'(`DAC_MID)});
  release_reset();
  wait_for("status", 200);
  repeat (5) @(negedge clk);
  exp                 = '0;
  exp.delay_too_short = 1'b1;
  compare_status(status, exp, "short DAC_WR delay");
  compare_count(ldac_cnt, 0, "ldac pulses");
endtask

task automatic test_underflow_bad_code();
  dac_cmd_pkg::dac_status_t exp;
  begin_test("data word underflow");
  cmd_q.push_back(delay_cmd(dac_cmd_pkg::DAC_WR, 1'b1, 25'd1000));
  repeat (2) cmd_q.push_back({16'(`DAC_MID), 16'(`DAC_MID)});  // Half the data
  release_reset();
  wait_for("status", 300);
  repeat (5) @(negedge clk);
  exp                   = '0;
  exp.cmd_buf_underflow = 1'b1;
  compare_status(status, exp, "two data words");

  begin_test("forbidden code");
  cmd_q.push_back(chan_cmd(dac_cmd_pkg::DAC_WR_CH, 3'd1, 16'(`DAC_CODE_BAD)));
  release_reset();
  wait_for("status", 100);
  check_quiet(60);
  exp             = '0;
  exp.dac_val_oob = 1'b1;
  compare_status(status, exp, "code 65535");
endtask

`endif

/* verif/tb_dac_ctrl.sv */
`timescale 1ns/1ps
`include "dac_ctrl_defines.svh"

module tb_dac_ctrl;

  localparam int CLK_PERIOD  = 40;
  localparam int NUM_TESTS   = 6;
  localparam int TEST_CYCLES = 2000;  // Watchdog budget per test

  logic                     clk;
  logic                     resetn;
  logic [31:0]              cmd_buf_word;
  logic                     cmd_buf_empty;
  logic                     cmd_buf_rd_en;
  logic [`CS_GAP_W-1:0]     n_cs_high_time;
  logic                     n_cs;
  logic                     mosi;
  logic                     ldac;
  logic                     busy;
  dac_cmd_pkg::dac_status_t status;

  logic [31:0]              cmd_q[$];   // Buffer contents, head first
  dac_spi_pkg::spi_frame_t  obs_q[$];   // Frames seen on the pins
  logic [31:0]              lfsr;
  logic                     pop_seen;   // Head taken at the last rising edge
  logic [`SPI_FRAME_W-1:0]  mon_shift;
  int                       mon_bits;
  int                       ldac_cnt;

  dac_ctrl_top u_dut (
    .clk            (clk),
    .resetn         (resetn),
    .cmd_buf_word   (cmd_buf_word),
    .cmd_buf_empty  (cmd_buf_empty),
    .cmd_buf_rd_en  (cmd_buf_rd_en),
    .n_cs_high_time (n_cs_high_time),
    .n_cs           (n_cs),
    .mosi           (mosi),
    .ldac           (ldac),
    .busy           (busy),
    .status         (status)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Show-ahead command buffer and SPI monitor
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    pop_seen <= resetn && cmd_buf_rd_en;  // No pops while in reset
  end

  // Head changes half a cycle after the pop
  initial begin
    cmd_buf_word  = '0;
    cmd_buf_empty = 1'b1;
    forever begin
      @(negedge clk);
      if (pop_seen && cmd_q.size() > 0) void'(cmd_q.pop_front());
      cmd_buf_empty = (cmd_q.size() == 0);
      cmd_buf_word  = cmd_buf_empty ? 32'h0 : cmd_q[0];
    end
  end

  always @(posedge clk) begin
    if (!resetn) begin
      mon_bits = 0;
      ldac_cnt = 0;
    end else begin
      if (ldac) ldac_cnt++;
      if (n_cs && mosi) report_failure("mosi is high while n_cs is high");
      if (!n_cs) begin
        mon_shift = {mon_shift[`SPI_FRAME_W-2:0], mosi};  // MSB arrives first
        mon_bits++;
        if (mon_bits == `SPI_FRAME_W) begin
          obs_q.push_back(dac_spi_pkg::spi_frame_t'(mon_shift));
          mon_bits = 0;
        end
      end
    end
  end

  initial begin
    #(CLK_PERIOD * NUM_TESTS * TEST_CYCLES);
    $display("Done: errors found");
    $fatal(1, "Watchdog expired before the tests finished");
  end

  //////////////////////////////////////////////////
  // Checks and random values
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_failure(input string msg);
    $display("Error at %0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic compare_frame(input dac_spi_pkg::spi_frame_t got,
                               input dac_spi_pkg::spi_frame_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got op %h ch %0d code %h, expected op %h ch %0d code %h",
               $time, what, got.op, got.channel, got.code, exp.op, exp.channel, exp.code);
      abort_run();
    end
  endtask

  task automatic compare_status(input dac_cmd_pkg::dac_status_t got,
                                input dac_cmd_pkg::dac_status_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s status %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};  // One step per bit
    end
    return v;
  endfunction

  // REG_WRITE frame as the DAC expects it
  function automatic dac_spi_pkg::spi_frame_t make_frame(input logic [`DAC_CH_W-1:0] ch,
                                                         input logic [`DAC_VAL_W-1:0] code);
    dac_spi_pkg::spi_frame_t f;
    f.op      = dac_spi_pkg::REG_WRITE;
    f.rsvd    = 1'b0;
    f.channel = ch;
    f.code    = code;
    return f;
  endfunction

  `include "tb_dac_ctrl_tasks.svh"

  initial begin
    resetn         = 1'b0;
    n_cs_high_time = `CS_GAP_W'(3);
    lfsr           = 32'h742a_0d7a;
    test_single_channel();
    test_full_update();
    test_cancel_delay();
    test_cal_out_of_range();
    test_bad_cmd_short_delay();
    test_underflow_bad_code();
    $display("Done: no errors");
    $finish;
  end

endmodule

/* sources.f */
+incdir+src
+incdir+verif
src/dac_cmd_pkg.sv
src/dac_spi_pkg.sv
src/dac_cmd_parser.sv
src/dac_cal_stage.sv
src/dac_spi_tx.sv
src/dac_ctrl_top.sv
verif/tb_dac_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Builds the DAC controller testbench with Verilator and runs it
# The exit status is that of the failing step, or 0 when all passes

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dac_ctrl \
  -f sources.f \
  --Mdir obj_dir -o sim_dac_ctrl
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build returned status $status"
  exit $status
fi

./obj_dir/sim_dac_ctrl
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation returned status $status"
  exit $status
fi

exit 0
